// ==== project.f ====
+incdir+.
lat_mon_pkg.sv
lat_event_capture.sv
lat_stamp_fifo.sv
lat_delta_stats.sv
lat_pair_readout.sv
lat_mon_top.sv
tb_lat_mon.sv

// ==== Makefile ====
TOOL       ?= verilator
TOP        ?= tb_lat_mon
FILELIST   ?= project.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_lat_mon_model.svh ====
// Reference model: pending count, send and pair queues, expected statistics, compare tasks
`ifndef TB_LAT_MON_MODEL_SVH
`define TB_LAT_MON_MODEL_SVH

int          checks;
int          errors;
int          m_pending;
int          m_sfill;
int          m_expected;
int          m_popped;
longint      send_cyc_q [$];
logic [15:0] gap_q [$];
logic [15:0] pair_send_q [$];
logic [15:0] prev_exp_send;
logic [15:0] prev_act_send;
logic        have_prev;
logic [31:0] m_sum;
logic [31:0] m_count;
logic [15:0] m_max;
logic [15:0] m_min;

task automatic compare_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic reset_model();
    m_pending  = 0;
    m_sfill    = 0;
    m_expected = 0;
    m_popped   = 0;
    send_cyc_q.delete();
    gap_q.delete();
    pair_send_q.delete();
    have_prev  = 1'b0;
    m_sum      = '0;
    m_count    = '0;
    m_max      = '0;
    m_min      = '1;
endtask

// Same gating as the DUT, applied to the values it samples next edge
task automatic record_event(input logic sent, input logic rcvd, input logic go,
                            input longint cyc);
    logic   take_rcvd;
    longint scyc;
    // Receive gating sees pending before this cycle's send
    take_rcvd = rcvd && (m_pending != 0);
    if (sent && go && (m_sfill < DEPTH)) begin
        send_cyc_q.push_back(cyc);
        m_pending++;
        m_sfill++;
    end
    if (take_rcvd) begin
        scyc = send_cyc_q.pop_front();
        gap_q.push_back(16'(cyc - scyc));
        pair_send_q.push_back(16'(scyc));
        m_pending--;
        m_expected++;
    end
endtask

// One record leaves the DUT
task automatic retire_record(input lat_mon_pkg::lat_record_t rec);
    logic [15:0] gap;
    logic [15:0] scyc;
    logic [15:0] lat;
    m_popped++;
    m_sfill--;
    if (gap_q.size() == 0) begin
        errors++;
        $display("A record came out that the model has no pair for");
    end else begin
        gap  = gap_q.pop_front();
        scyc = pair_send_q.pop_front();
        compare_val("pair latency", {16'd0, gap}, {16'd0, rec.rcvd - rec.send});
        // Spacing of send stamps shows the records keep their order
        if (have_prev) begin
            compare_val("send order", {16'd0, scyc - prev_exp_send},
                        {16'd0, rec.send - prev_act_send});
        end
        have_prev     = 1'b1;
        prev_exp_send = scyc;
        prev_act_send = rec.send;
        lat     = gap - 16'(ADJ);
        m_sum   = m_sum + {16'd0, lat};
        m_count = m_count + 32'd1;
        if (lat > m_max) begin
            m_max = lat;
        end
        if (lat < m_min) begin
            m_min = lat;
        end
    end
endtask

task automatic check_stats(input string name);
    compare_val({name, " sum"}, m_sum, o_stats.sum);
    compare_val({name, " count"}, m_count, o_stats.count);
    compare_val({name, " max"}, {16'd0, m_max}, {16'd0, o_stats.max});
    compare_val({name, " min"}, {16'd0, m_min}, {16'd0, o_stats.min});
endtask

`endif

// ==== tb_lat_mon.sv ====
// Latency monitor testbench: clock, reset, LFSR stimulus, record monitor, phase checks, report
`timescale 1ns/1ps
`default_nettype none

module tb_lat_mon;

    localparam int DEPTH      = lat_mon_pkg::DEF_FIFO_DEPTH;
    localparam int ADJ        = lat_mon_pkg::DEF_ADJ_FACTOR;
    localparam int CLK_PERIOD = 4;

    logic                      lat_clk;
    logic                      lat_rstn;
    logic                      i_pkt_sent;
    logic                      i_pkt_rcvd;
    logic                      i_go;
    logic                      i_clear;
    logic [31:0]               i_pkt_cnt;
    logic                      i_rec_ready;
    lat_mon_pkg::lat_record_t  o_rec;
    logic                      o_rec_valid;
    logic [$clog2(DEPTH):0]    o_count;
    logic                      o_full;
    lat_mon_pkg::lat_stats_t   o_stats;
    logic                      o_done;
    logic [31:0]               lfsr;

    `include "tb_lat_mon_model.svh"

    lat_mon_top dut0 (
        .lat_clk     (lat_clk),
        .lat_rstn    (lat_rstn),
        .i_pkt_sent  (i_pkt_sent),
        .i_pkt_rcvd  (i_pkt_rcvd),
        .i_go        (i_go),
        .i_clear     (i_clear),
        .i_pkt_cnt   (i_pkt_cnt),
        .i_rec_ready (i_rec_ready),
        .o_rec       (o_rec),
        .o_rec_valid (o_rec_valid),
        .o_count     (o_count),
        .o_full      (o_full),
        .o_stats     (o_stats),
        .o_done      (o_done)
    );

    initial begin
        lat_clk = 1'b0;
        forever #(CLK_PERIOD / 2) lat_clk = ~lat_clk;
    end

    // ########################################
    // Helpers
    // ########################################

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ ({32{s[0]}} & 32'h8020_0003);
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic drive_cycle(input logic sent, input logic rcvd, input logic go);
        @(posedge lat_clk);
        i_pkt_sent <= sent;
        i_pkt_rcvd <= rcvd;
        i_go       <= go;
        record_event(sent, rcvd, go, longint'($time) / CLK_PERIOD);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge lat_clk);
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    task automatic wait_drain(input string what);
        int t;
        t = 0;
        while (gap_q.size() != 0 && t < 200) begin
            @(negedge lat_clk);
            t++;
        end
        if (gap_q.size() != 0) begin
            timeout_fail({"records of ", what, " never all came out"});
        end
    endtask

    // Transfer happens on the next rising edge
    always @(negedge lat_clk) begin
        if (lat_rstn && o_rec_valid && i_rec_ready) begin
            retire_record(o_rec);
        end
    end

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        logic s;
        logic r;
        int   t;
        int   popped_before;
        lfsr        = 32'h4927;
        lat_rstn    = 1'b0;
        i_pkt_sent  = 1'b0;
        i_pkt_rcvd  = 1'b0;
        i_go        = 1'b0;
        i_clear     = 1'b0;
        i_pkt_cnt   = '0;
        i_rec_ready = 1'b0;
        checks      = 0;
        errors      = 0;
        reset_model();
        repeat (2) @(posedge lat_clk);
        lat_rstn    <= 1'b1;
        i_rec_ready <= 1'b1;

        // Random traffic, sends held back once 8 are pending
        for (int n = 0; n < 300; n++) begin
            draw_bit(s);
            draw_bit(r);
            drive_cycle(s && (m_pending < 8), r, 1'b1);
        end
        while (m_pending != 0) begin
            drive_cycle(1'b0, 1'b1, 1'b1);
        end
        drive_cycle(1'b0, 1'b0, 1'b1);
        wait_drain("random traffic");
        compare_val("random records", m_expected, m_popped);

        // Gated events must leave no trace
        for (int n = 0; n < 40; n++) begin
            draw_bit(s);
            draw_bit(r);
            drive_cycle(s, r, 1'b0);
        end
        drive_cycle(1'b0, 1'b0, 1'b0);
        wait_cycles(4);
        compare_val("gated count", 0, 32'(o_count));
        compare_val("gated valid", 0, 32'(o_rec_valid));
        compare_val("gated records", m_expected, m_popped);

        // Back-pressure until the send store is full
        popped_before = m_popped;
        @(posedge lat_clk);
        i_rec_ready <= 1'b0;
        for (int n = 0; n < DEPTH + 4; n++) begin
            drive_cycle(1'b1, 1'b0, 1'b1);
        end
        drive_cycle(1'b0, 1'b0, 1'b1);
        t = 0;
        while (!o_full && t < 50) begin
            @(negedge lat_clk);
            t++;
        end
        if (!o_full) begin
            timeout_fail("send store never reported full");
        end
        wait_cycles(2);
        compare_val("full flag", 1, 32'(o_full));
        compare_val("full count", DEPTH, 32'(o_count));
        for (int n = 0; n < DEPTH + 4; n++) begin
            drive_cycle(1'b0, 1'b1, 1'b1);
        end
        drive_cycle(1'b0, 1'b0, 1'b1);
        @(posedge lat_clk);
        i_rec_ready <= 1'b1;
        wait_drain("back-pressure");
        compare_val("records after full", DEPTH, m_popped - popped_before);

        // Statistics trail the last transfer
        t = 0;
        while (o_stats.count !== m_count && t < 50) begin
            @(negedge lat_clk);
            t++;
        end
        if (o_stats.count !== m_count) begin
            timeout_fail("statistics count never reached the popped total");
        end
        wait_cycles(2);
        check_stats("stats");
        compare_val("done below count", 0, 32'(o_done));
        @(posedge lat_clk);
        i_pkt_cnt <= m_count;
        wait_cycles(3);
        compare_val("done at count", 1, 32'(o_done));

        // Clear with a record waiting
        @(posedge lat_clk);
        i_rec_ready <= 1'b0;
        drive_cycle(1'b1, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b1);
        drive_cycle(1'b0, 1'b0, 1'b1);
        t = 0;
        while (!o_rec_valid && t < 20) begin
            @(negedge lat_clk);
            t++;
        end
        if (!o_rec_valid) begin
            timeout_fail("record before clear never became valid");
        end
        @(posedge lat_clk);
        i_clear <= 1'b1;
        @(posedge lat_clk);
        i_clear     <= 1'b0;
        i_rec_ready <= 1'b1;
        reset_model();
        wait_cycles(3);
        compare_val("clear valid", 0, 32'(o_rec_valid));
        compare_val("clear count", 0, 32'(o_count));
        check_stats("clear stats");
        drive_cycle(1'b1, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b1);
        drive_cycle(1'b0, 1'b0, 1'b1);
        wait_drain("after clear");
        compare_val("records after clear", 1, m_popped);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== lat_mon_top.sv ====
// Latency monitor top: event capture, send and receive stamp stores, pair readout
`timescale 1ns/1ps
`default_nettype none

module lat_mon_top #(
    parameter int FIFO_DEPTH = lat_mon_pkg::DEF_FIFO_DEPTH,
    parameter int ADJ_FACTOR = lat_mon_pkg::DEF_ADJ_FACTOR
) (
    input  wire                             lat_clk,
    input  wire                             lat_rstn,
    input  logic                            i_pkt_sent,
    input  logic                            i_pkt_rcvd,
    input  logic                            i_go,
    input  logic                            i_clear,
    input  logic [31:0]                     i_pkt_cnt,
    input  logic                            i_rec_ready,
    output lat_mon_pkg::lat_record_t        o_rec,
    output logic                            o_rec_valid,
    output logic [$clog2(FIFO_DEPTH):0]     o_count,
    output logic                            o_full,
    output lat_mon_pkg::lat_stats_t         o_stats,
    output logic                            o_done
);

    localparam int NS = lat_mon_pkg::NUM_STORES;

    lat_mon_pkg::stamp_wr_t         wr       [NS];
    lat_mon_pkg::stamp_t            heads    [NS];
    logic [$clog2(FIFO_DEPTH):0]    counts   [NS];
    logic [NS-1:0]                  full;
    logic [NS-1:0]                  not_empty;
    logic [NS-1:0]                  pop;

    lat_event_capture #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_capture (
        .lat_clk    (lat_clk),
        .lat_rstn   (lat_rstn),
        .i_pkt_sent (i_pkt_sent),
        .i_pkt_rcvd (i_pkt_rcvd),
        .i_go       (i_go),
        .i_clear    (i_clear),
        .i_full     (full),
        .o_wr       (wr)
    );

    // Store 0 takes send stamps, store 1 receive stamps
    for (genvar g = 0; g < NS; g++) begin : g_store
        lat_stamp_fifo #(
            .FIFO_DEPTH  (FIFO_DEPTH)
        ) u_fifo (
            .lat_clk     (lat_clk),
            .lat_rstn    (lat_rstn),
            .i_clear     (i_clear),
            .i_wr        (wr[g]),
            .i_pop       (pop[g]),
            .o_head      (heads[g]),
            .o_not_empty (not_empty[g]),
            .o_count     (counts[g]),
            .o_full      (full[g])
        );
    end

    lat_pair_readout #(
        .ADJ_FACTOR  (ADJ_FACTOR)
    ) u_readout (
        .lat_clk     (lat_clk),
        .lat_rstn    (lat_rstn),
        .i_clear     (i_clear),
        .i_pkt_cnt   (i_pkt_cnt),
        .i_heads     (heads),
        .i_not_empty (not_empty),
        .i_rec_ready (i_rec_ready),
        .o_pop       (pop),
        .o_rec       (o_rec),
        .o_rec_valid (o_rec_valid),
        .o_stats     (o_stats),
        .o_done      (o_done)
    );

    // Status follows the send store
    assign o_count = counts[0];
    assign o_full  = full[0];

endmodule

`default_nettype wire

// ==== lat_pair_readout.sv ====
// Pair readout: joins both store heads into one record over valid/ready, feeds statistics
`timescale 1ns/1ps
`default_nettype none

module lat_pair_readout #(
    parameter int ADJ_FACTOR = 1
) (
    input  wire                                  lat_clk,
    input  wire                                  lat_rstn,
    input  logic                                 i_clear,
    input  logic [31:0]                          i_pkt_cnt,
    input  lat_mon_pkg::stamp_t                  i_heads [lat_mon_pkg::NUM_STORES],
    input  logic [lat_mon_pkg::NUM_STORES-1:0]   i_not_empty,
    input  logic                                 i_rec_ready,
    output logic [lat_mon_pkg::NUM_STORES-1:0]   o_pop,
    output lat_mon_pkg::lat_record_t             o_rec,
    output logic                                 o_rec_valid,
    output lat_mon_pkg::lat_stats_t              o_stats,
    output logic                                 o_done
);

    logic xfer;

    // ########################################
    // Record handshake
    // ########################################

    // A record exists only when both sides hold a stamp
    assign o_rec_valid = &i_not_empty;
    assign xfer        = o_rec_valid & i_rec_ready;

    assign o_rec.send = i_heads[0];
    assign o_rec.rcvd = i_heads[1];

    // Both stores advance together
    assign o_pop = {lat_mon_pkg::NUM_STORES{xfer}};

    // ########################################
    // Statistics
    // ########################################

    lat_delta_stats #(
        .ADJ_FACTOR   (ADJ_FACTOR)
    ) u_stats (
        .lat_clk      (lat_clk),
        .lat_rstn     (lat_rstn),
        .i_clear      (i_clear),
        .i_rec        (o_rec),
        .i_rec_strobe (xfer),
        .i_pkt_cnt    (i_pkt_cnt),
        .o_stats      (o_stats),
        .o_done       (o_done)
    );

endmodule

`default_nettype wire

// ==== lat_delta_stats.sv ====
// Latency statistics: per-record latency, running sum, count, maximum, minimum, done flag
`timescale 1ns/1ps
`default_nettype none

module lat_delta_stats #(
    parameter int ADJ_FACTOR = 1
) (
    input  wire                         lat_clk,
    input  wire                         lat_rstn,
    input  logic                        i_clear,
    input  lat_mon_pkg::lat_record_t    i_rec,
    input  logic                        i_rec_strobe,
    input  logic [31:0]                 i_pkt_cnt,
    output lat_mon_pkg::lat_stats_t     o_stats,
    output logic                        o_done
);

    lat_mon_pkg::stamp_t    delta;
    logic                   delta_vld;
    lat_mon_pkg::lat_stats_t stats;

    // ########################################
    // Stage 1, latency and count
    // ########################################

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            delta       <= '0;
            delta_vld   <= 1'b0;
            stats.count <= '0;
        end else begin
            delta_vld <= i_rec_strobe;
            if (i_rec_strobe) begin
                // Wraps modulo 2^16 with the timer
                delta       <= i_rec.rcvd - i_rec.send
                               - lat_mon_pkg::STAMP_W'(ADJ_FACTOR);
                stats.count <= stats.count + 1'b1;
            end
        end
    end

    // ########################################
    // Stage 2, sum and extremes
    // ########################################

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            stats.sum <= '0;
            stats.max <= '0;
            stats.min <= '1;
        end else if (delta_vld) begin
            stats.sum <= stats.sum + {16'd0, delta};
            if (delta > stats.max) begin
                stats.max <= delta;
            end
            if (delta < stats.min) begin
                stats.min <= delta;
            end
        end
    end

    // Done trails the count by a cycle
    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            o_done <= 1'b0;
        end else begin
            o_done <= (stats.count == i_pkt_cnt) && (stats.count != '0);
        end
    end

    assign o_stats = stats;

endmodule

`default_nettype wire

// ==== lat_stamp_fifo.sv ====
// Show-ahead stamp FIFO with fill count and full flag
`timescale 1ns/1ps
`default_nettype none

module lat_stamp_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                              lat_clk,
    input  wire                              lat_rstn,
    input  logic                             i_clear,
    input  lat_mon_pkg::stamp_wr_t           i_wr,
    input  logic                             i_pop,
    output lat_mon_pkg::stamp_t              o_head,
    output logic                             o_not_empty,
    output logic [$clog2(FIFO_DEPTH):0]      o_count,
    output logic                             o_full
);

    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int CNT_W = AW + 1;

    lat_mon_pkg::stamp_t mem [FIFO_DEPTH];

    // Pointers carry one wrap bit above the address
    logic [AW:0]        wr_ptr;
    logic [AW:0]        rd_ptr;
    logic [AW:0]        wr_ptr_nxt;
    logic [AW:0]        rd_ptr_nxt;
    logic [CNT_W-1:0]   count_nxt;
    logic [CNT_W-1:0]   count_q;
    logic               full_q;
    logic               not_empty_q;

    assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, i_wr.wr};
    assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, i_pop};
    assign count_nxt  = wr_ptr_nxt - rd_ptr_nxt;

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count_q     <= '0;
            full_q      <= 1'b0;
            not_empty_q <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr_nxt;
            rd_ptr      <= rd_ptr_nxt;
            count_q     <= count_nxt;
            full_q      <= (count_nxt == CNT_W'(FIFO_DEPTH));
            not_empty_q <= (count_nxt != '0);
        end
    end

    // ########################################
    // Storage
    // ########################################

    always_ff @(posedge lat_clk) begin
        if (i_wr.wr && !i_clear) begin
            mem[wr_ptr[AW-1:0]] <= i_wr.stamp;
        end
    end

    // Head is visible without a read request
    assign o_head      = mem[rd_ptr[AW-1:0]];
    assign o_not_empty = not_empty_q;
    assign o_count     = count_q;

    // Also counts a write already on its way in, so the
    // writer sees the last free slot as taken in time
    assign o_full = full_q |
                    ((count_q == CNT_W'(FIFO_DEPTH - 1)) & i_wr.wr & ~i_pop);

endmodule

`default_nettype wire

// ==== lat_event_capture.sv ====
// Event capture: free-running timer, send/receive gating, pending count, store write strobes
`timescale 1ns/1ps
`default_nettype none

module lat_event_capture #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                                   lat_clk,
    input  wire                                   lat_rstn,
    input  logic                                  i_pkt_sent,
    input  logic                                  i_pkt_rcvd,
    input  logic                                  i_go,
    input  logic                                  i_clear,
    input  logic [lat_mon_pkg::NUM_STORES-1:0]    i_full,
    output lat_mon_pkg::stamp_wr_t                o_wr [lat_mon_pkg::NUM_STORES]
);

    // Pending never exceeds the send store depth
    localparam int PEND_W = $clog2(FIFO_DEPTH) + 1;

    lat_mon_pkg::stamp_t                 timer;
    logic [PEND_W-1:0]                   pending;
    logic [lat_mon_pkg::NUM_STORES-1:0]  accept;
    logic [lat_mon_pkg::NUM_STORES-1:0]  wr_q;
    lat_mon_pkg::stamp_t                 stamp_q [lat_mon_pkg::NUM_STORES];

    // ########################################
    // Timer
    // ########################################

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // ########################################
    // Event gating
    // ########################################

    // A receive needs an outstanding send
    assign accept[0] = i_pkt_sent & i_go & ~i_full[0];
    assign accept[1] = i_pkt_rcvd & (pending != '0) & ~i_full[1];

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            pending <= '0;
        end else begin
            case (accept)
                2'b01:   pending <= pending + 1'b1;
                2'b10:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    // ########################################
    // Store writes
    // ########################################

    always_ff @(posedge lat_clk) begin
        if (!lat_rstn || i_clear) begin
            wr_q <= '0;
        end else begin
            wr_q <= accept;
        end
    end

    // Stamp of the cycle the event was sampled
    always_ff @(posedge lat_clk) begin
        for (int i = 0; i < lat_mon_pkg::NUM_STORES; i++) begin
            if (accept[i]) begin
                stamp_q[i] <= timer;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lat_mon_pkg::NUM_STORES; i++) begin
            o_wr[i].wr    = wr_q[i];
            o_wr[i].stamp = stamp_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== lat_mon_pkg.sv ====
// Latency monitor package: stamp width, stamp/write/record/statistics types, default sizes
`default_nettype none

package lat_mon_pkg;

    // ########################################
    // Widths and sizes
    // ########################################

    // Timer and stamp width
    localparam int STAMP_W = 16;

    // Store 0 holds send stamps, store 1 holds receive stamps
    localparam int NUM_STORES = 2;

    // Defaults for the top level parameters
    localparam int DEF_FIFO_DEPTH = 16;
    localparam int DEF_ADJ_FACTOR = 1;

    // ########################################
    // Types
    // ########################################

    typedef logic [STAMP_W-1:0] stamp_t;

    // One write into a stamp store
    typedef struct packed {
        logic   wr;
        stamp_t stamp;
    } stamp_wr_t;

    // Send stamp sits in the upper half
    typedef struct packed {
        stamp_t send;
        stamp_t rcvd;
    } lat_record_t;

    // Running latency statistics
    typedef struct packed {
        logic [31:0] sum;
        logic [31:0] count;
        stamp_t      max;
        stamp_t      min;
    } lat_stats_t;

endpackage

`default_nettype wire
